// File: Makefile
VERILATOR  ?= verilator
TOP        := platform_core_tb
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) include/platform_config.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/platform_config.svh
//************************************************
// Platform core configuration
// Bus widths, stream widths and power-on length
//************************************************
`ifndef PLATFORM_CONFIG_SVH
`define PLATFORM_CONFIG_SVH

// Register bus
`define PLAT_DATA_W       32
`define PLAT_ADDR_W       13
`define PLAT_REG_IDX_LSB  4
`define PLAT_REG_IDX_W    9
`define PLAT_BE_W         4
`define PLAT_FW_VERSION   32'h0001_0002
`define PLAT_LED_W        4

// Hold time after external reset release
`define PLAT_POR_CYCLES   16

// Camera and pixel stream
`define PLAT_PIX_IN_W     16
`define PLAT_PIX_OUT_W    24

// Monitor field widths, these sum to the data width
`define PLAT_SOF_CNT_W    8
`define PLAT_EOL_CNT_W    12
`define PLAT_BEAT_CNT_W   12

`endif

// File: logic/pixel_pkg.sv
//************************************************
// Camera pixel word layout
//************************************************
`include "platform_config.svh"

package pixel_pkg;

   // Camera halfword, raw or as colour fields
   // Blue sits on top, red in the low bits
   typedef union packed {
      logic [`PLAT_PIX_IN_W-1:0] raw;
      struct packed {
         logic [4:0] blue;
         logic [5:0] green;
         logic [4:0] red;
      } fld;
   } pix565_u;

endpackage

// File: logic/pixel_unpack.sv
//************************************************
// RGB565 to RGB888 unpacker, one register stage
//************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module pixel_unpack
   import pixel_pkg::*;
(
   input  logic                       reg_ctrl_clk,
   input  logic                       rst_n_i,
   input  logic                       sys_ready_i,
   input  logic                       cam_valid_i,
   input  logic                       cam_sof_i,
   input  logic                       cam_eol_i,
   input  pix565_u                    cam_pix_i,
   output logic                       pix_valid_o,
   output logic                       pix_sof_o,
   output logic                       pix_eol_o,
   output logic [`PLAT_PIX_OUT_W-1:0] pix_data_o
);

   logic beat_in;

   // Beats before ready are dropped
   assign beat_in = cam_valid_i && sys_ready_i;

   // Strobe and flags, flags cleared off-beat
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         pix_valid_o <= 1'b0;
         pix_sof_o   <= 1'b0;
         pix_eol_o   <= 1'b0;
      end
      else
      begin
         pix_valid_o <= beat_in;
         pix_sof_o   <= beat_in && cam_sof_i;
         pix_eol_o   <= beat_in && cam_eol_i;
      end
   end

   // Lanes R, B, G from the top, low bits zero
   always_ff @(posedge reg_ctrl_clk)
   begin
      if (beat_in)
         pix_data_o <= {cam_pix_i.fld.red,   3'd0,
                        cam_pix_i.fld.blue,  3'd0,
                        cam_pix_i.fld.green, 2'd0};
   end

endmodule

// File: logic/platform_core.sv
//************************************************
// Platform core top, register and pixel paths
//************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module platform_core
(
   input  logic                       reg_ctrl_clk,
   input  logic                       rst_n_i,
   // Register bus
   input  logic                       reg_en_i,
   input  logic [`PLAT_BE_W-1:0]      reg_we_i,
   input  logic [`PLAT_ADDR_W-1:0]    reg_addr_i,
   input  logic [`PLAT_DATA_W-1:0]    reg_wdata_i,
   output logic [`PLAT_DATA_W-1:0]    reg_rdata_o,
   // Camera stream in
   input  logic                       cam_valid_i,
   input  logic                       cam_sof_i,
   input  logic                       cam_eol_i,
   input  logic [`PLAT_PIX_IN_W-1:0]  cam_pix_i,
   // Pixel stream out
   output logic                       pix_valid_o,
   output logic                       pix_sof_o,
   output logic                       pix_eol_o,
   output logic [`PLAT_PIX_OUT_W-1:0] pix_data_o,
   // Status
   output logic [`PLAT_DATA_W-1:0]    mon_cnt_o,
   output logic [`PLAT_LED_W-1:0]     led_o,
   output logic                       sys_ready_o
);

   //************************************************
   // Power-on hold
   //************************************************
   por_sequencer u_por_sequencer
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .rst_n_i      ( rst_n_i ),
      .sys_ready_o  ( sys_ready_o )
   );

   //************************************************
   // Control registers
   //************************************************
   reg_bank u_reg_bank
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .rst_n_i      ( rst_n_i ),
      .sys_ready_i  ( sys_ready_o ),
      .reg_en_i     ( reg_en_i ),
      .reg_we_i     ( reg_we_i ),
      .reg_addr_i   ( reg_addr_i ),
      .reg_wdata_i  ( reg_wdata_i ),
      // Count word shared with the status port
      .mon_cnt_i    ( mon_cnt_o ),
      .reg_rdata_o  ( reg_rdata_o ),
      .led_o        ( led_o )
   );

   //************************************************
   // Pixel path
   //************************************************
   pixel_unpack u_pixel_unpack
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .rst_n_i      ( rst_n_i ),
      .sys_ready_i  ( sys_ready_o ),
      .cam_valid_i  ( cam_valid_i ),
      .cam_sof_i    ( cam_sof_i ),
      .cam_eol_i    ( cam_eol_i ),
      .cam_pix_i    ( cam_pix_i ),
      .pix_valid_o  ( pix_valid_o ),
      .pix_sof_o    ( pix_sof_o ),
      .pix_eol_o    ( pix_eol_o ),
      .pix_data_o   ( pix_data_o )
   );

   // Watches the unpacked stream
   stream_monitor u_stream_monitor
   (
      .reg_ctrl_clk ( reg_ctrl_clk ),
      .rst_n_i      ( rst_n_i ),
      .sys_ready_i  ( sys_ready_o ),
      .pix_valid_i  ( pix_valid_o ),
      .pix_sof_i    ( pix_sof_o ),
      .pix_eol_i    ( pix_eol_o ),
      .mon_cnt_o    ( mon_cnt_o )
   );

endmodule

// File: logic/por_sequencer.sv
//************************************************
// Power-on sequencer, holds core until count done
//************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module por_sequencer
(
   input  logic reg_ctrl_clk,
   input  logic rst_n_i,
   output logic sys_ready_o
);

   localparam int CNT_W = $clog2(`PLAT_POR_CYCLES + 1);

   logic [CNT_W-1:0] por_cnt;

   // Saturating hold counter
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         por_cnt <= '0;
      else if (por_cnt != CNT_W'(`PLAT_POR_CYCLES))
         por_cnt <= por_cnt + 1'b1;
   end

   // Ready rises on the last hold edge and stays
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         sys_ready_o <= 1'b0;
      else if (por_cnt >= CNT_W'(`PLAT_POR_CYCLES - 1))
         sys_ready_o <= 1'b1;
   end

endmodule

// File: logic/reg_bank.sv
//************************************************
// Control register bank
// Byte-lane writes, registered reads, LED drive
//************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module reg_bank
   import reg_map_pkg::*;
(
   input  logic                    reg_ctrl_clk,
   input  logic                    rst_n_i,
   input  logic                    sys_ready_i,
   input  logic                    reg_en_i,
   input  logic [`PLAT_BE_W-1:0]   reg_we_i,
   input  logic [`PLAT_ADDR_W-1:0] reg_addr_i,
   input  logic [`PLAT_DATA_W-1:0] reg_wdata_i,
   input  mon_cnt_u                mon_cnt_i,
   output logic [`PLAT_DATA_W-1:0] reg_rdata_o,
   output logic [`PLAT_LED_W-1:0]  led_o
);

   //************************************************
   // Decode
   //************************************************
   logic [`PLAT_REG_IDX_W-1:0] reg_idx;
   logic                       wr_req;
   logic                       rd_req;
   logic [`PLAT_DATA_W-1:0]    led_ctrl_q;
   logic [`PLAT_DATA_W-1:0]    rd_word;

   // Register index from byte address
   assign reg_idx = reg_addr_i[`PLAT_REG_IDX_LSB +: `PLAT_REG_IDX_W];

   // Accesses ignored until power-on done
   assign wr_req = sys_ready_i && reg_en_i && (reg_we_i != '0);
   assign rd_req = sys_ready_i && reg_en_i && (reg_we_i == '0);

   //************************************************
   // LED control register
   //************************************************
   // Only the set lanes change
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         led_ctrl_q <= '0;
      else if (wr_req && (reg_idx == REG_IDX_LED_CTRL))
      begin
         for (int b = 0; b < `PLAT_BE_W; b++)
         begin
            if (reg_we_i[b])
               led_ctrl_q[b*8 +: 8] <= reg_wdata_i[b*8 +: 8];
         end
      end
   end

   // LED pins from low field
   assign led_o = led_ctrl_q[`PLAT_LED_W-1:0];

   //************************************************
   // Read path
   //************************************************
   // Unmapped indices give zero
   always_comb
   begin
      case (reg_idx)
         REG_IDX_FW_VER:   rd_word = `PLAT_FW_VERSION;
         REG_IDX_LED_CTRL: rd_word = led_ctrl_q;
         REG_IDX_MON_CNT:  rd_word = mon_cnt_i.raw;
         default:          rd_word = '0;
      endcase
   end

   // One cycle latency, held until next read
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         reg_rdata_o <= '0;
      else if (rd_req)
         reg_rdata_o <= rd_word;
   end

endmodule

// File: logic/reg_map_pkg.sv
//************************************************
// Register map of the control bank
// Indices and the monitor count word layout
//************************************************
`include "platform_config.svh"

package reg_map_pkg;

   //************************************************
   // Register indices
   //************************************************
   // Firmware version, read only
   localparam logic [`PLAT_REG_IDX_W-1:0] REG_IDX_FW_VER   = 9'd0;
   // LED control, byte-lane writable
   localparam logic [`PLAT_REG_IDX_W-1:0] REG_IDX_LED_CTRL = 9'd1;
   // Stream counts, read only
   localparam logic [`PLAT_REG_IDX_W-1:0] REG_IDX_MON_CNT  = 9'd2;

   //************************************************
   // Monitor count word
   //************************************************
   // Raw view for the read mux, field view for the monitor
   typedef union packed {
      logic [`PLAT_DATA_W-1:0] raw;
      struct packed {
         logic [`PLAT_SOF_CNT_W-1:0]  sof_cnt;
         logic [`PLAT_EOL_CNT_W-1:0]  eol_cnt;
         logic [`PLAT_BEAT_CNT_W-1:0] beat_cnt;
      } fld;
   } mon_cnt_u;

endpackage

// File: logic/stream_monitor.sv
//************************************************
// Stream monitor, counts starts, line ends, beats
//************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module stream_monitor
   import reg_map_pkg::*;
(
   input  logic     reg_ctrl_clk,
   input  logic     rst_n_i,
   input  logic     sys_ready_i,
   input  logic     pix_valid_i,
   input  logic     pix_sof_i,
   input  logic     pix_eol_i,
   output mon_cnt_u mon_cnt_o
);

   logic beat;

   // Only count once the core is running
   assign beat = pix_valid_i && sys_ready_i;

   //************************************************
   // Counters
   //************************************************
   // Each field wraps at its own width
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         mon_cnt_o <= '0;
      else if (!sys_ready_i)
         // Held clear during power-on
         mon_cnt_o <= '0;
      else if (beat)
      begin
         mon_cnt_o.fld.beat_cnt <= mon_cnt_o.fld.beat_cnt + 1'b1;
         // Frame start
         if (pix_sof_i)
            mon_cnt_o.fld.sof_cnt <= mon_cnt_o.fld.sof_cnt + 1'b1;
         // Line end
         if (pix_eol_i)
            mon_cnt_o.fld.eol_cnt <= mon_cnt_o.fld.eol_cnt + 1'b1;
      end
   end

endmodule

// File: src.f
+incdir+include
logic/reg_map_pkg.sv
logic/pixel_pkg.sv
logic/por_sequencer.sv
logic/reg_bank.sv
logic/pixel_unpack.sv
logic/stream_monitor.sv
logic/platform_core.sv
testbench/tb_clock_gen.sv
testbench/platform_core_sva.sv
testbench/platform_core_tb.sv

// File: testbench/platform_core_sva.sv
//**************************************************
// Bound assertions on the platform core top level
//**************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module platform_core_sva
   import reg_map_pkg::*;
(
   input logic                    reg_ctrl_clk,
   input logic                    rst_n_i,
   input logic                    sys_ready_i,
   input logic                    cam_valid_i,
   input logic                    pix_valid_i,
   input logic                    reg_en_i,
   input logic [`PLAT_BE_W-1:0]   reg_we_i,
   input logic [`PLAT_ADDR_W-1:0] reg_addr_i,
   input logic [`PLAT_LED_W-1:0]  led_i
);

   logic led_written;

   // Set by the first accepted LED_CTRL write
   always_ff @(posedge reg_ctrl_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         led_written <= 1'b0;
      else if (sys_ready_i && reg_en_i && (reg_we_i != '0) &&
               (reg_addr_i[`PLAT_REG_IDX_LSB +: `PLAT_REG_IDX_W] == REG_IDX_LED_CTRL))
         led_written <= 1'b1;
   end

   //**************************************************
   // Stream timing
   //**************************************************
   // Accepted beat shows up one cycle later
   beat_follows: assert property (@(posedge reg_ctrl_clk) disable iff (!rst_n_i)
      (cam_valid_i && sys_ready_i) |=> pix_valid_i)
      else $error("pix_valid_o missing one cycle after an accepted beat");

   // Nothing leaves the unpacker before power-on is done
   quiet_before_ready: assert property (@(posedge reg_ctrl_clk) disable iff (!rst_n_i)
      !sys_ready_i |=> !pix_valid_i)
      else $error("pix_valid_o rose while the core was not ready");

   //**************************************************
   // LED drive
   //**************************************************
   led_off_until_write: assert property (@(posedge reg_ctrl_clk) disable iff (!rst_n_i)
      !led_written |-> (led_i == '0))
      else $error("led_o nonzero before any LED_CTRL write");

endmodule

bind platform_core platform_core_sva platform_core_sva_i
(
   .reg_ctrl_clk ( reg_ctrl_clk ),
   .rst_n_i      ( rst_n_i ),
   .sys_ready_i  ( sys_ready_o ),
   .cam_valid_i  ( cam_valid_i ),
   .pix_valid_i  ( pix_valid_o ),
   .reg_en_i     ( reg_en_i ),
   .reg_we_i     ( reg_we_i ),
   .reg_addr_i   ( reg_addr_i ),
   .led_i        ( led_o )
);

// File: testbench/platform_core_tb.sv
//**************************************************
// Platform core testbench driving register ops
// and pixel bursts against a stream reference model
//**************************************************
`timescale 1ns/1ps
`include "platform_config.svh"

module platform_core_tb;

   localparam int MAX_ROWS   = 32;
   localparam int ROW_BUDGET = 40;
   localparam int RST_CYCLES = 10;
   localparam int K_WRITE    = 0;
   localparam int K_READ     = 1;
   localparam int K_BURST    = 2;

   logic                       reg_ctrl_clk;
   logic                       rst_n_i;
   logic                       reg_en_i;
   logic [`PLAT_BE_W-1:0]      reg_we_i;
   logic [`PLAT_ADDR_W-1:0]    reg_addr_i;
   logic [`PLAT_DATA_W-1:0]    reg_wdata_i;
   logic [`PLAT_DATA_W-1:0]    reg_rdata_o;
   logic                       cam_valid_i;
   logic                       cam_sof_i;
   logic                       cam_eol_i;
   logic [`PLAT_PIX_IN_W-1:0]  cam_pix_i;
   logic                       pix_valid_o;
   logic                       pix_sof_o;
   logic                       pix_eol_o;
   logic [`PLAT_PIX_OUT_W-1:0] pix_data_o;
   logic [`PLAT_DATA_W-1:0]    mon_cnt_o;
   logic [`PLAT_LED_W-1:0]     led_o;
   logic                       sys_ready_o;

   // Operation table held as parallel arrays
   int                      row_kind [MAX_ROWS];
   logic [`PLAT_ADDR_W-1:0] row_addr [MAX_ROWS];
   logic [31:0]             row_data [MAX_ROWS];
   logic [3:0]              row_mask [MAX_ROWS];
   logic [31:0]             row_exp  [MAX_ROWS];
   int                      n_rows;
   bit                      table_loaded;
   bit                      ready_ok;
   int                      err_cnt;
   int                      chk_cnt;
   logic [31:0]             led_shadow;

   // Pixel reference model due at the next falling edge
   logic        exp_valid;
   logic        exp_sof;
   logic        exp_eol;
   logic [23:0] exp_data;

   tb_clock_gen #(.PERIOD_NS(8)) clk_gen_i (.clk_o(reg_ctrl_clk));

   platform_core platform_core_i (.*);

   //**************************************************
   // Reference functions
   //**************************************************
   // Red, blue and green bytes from the top with zero padding
   function automatic logic [23:0] rgb565_to_888(input logic [15:0] p);
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
      r = p[4:0];
      g = p[10:5];
      b = p[15:11];
      return {r, 3'b000, b, 3'b000, g, 2'b00};
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  mask);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++)
         if (mask[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];
      return res;
   endfunction

   // Burst word holds lines per frame, line length and beat count
   function automatic logic [31:0] burst_cfg(input int lpf, input int ll, input int beats);
      return {lpf[7:0], ll[7:0], beats[15:0]};
   endfunction

   // Expected count word from all bursts before a row
   function automatic logic [31:0] count_word(input int upto);
      int frames;
      int lines;
      int beats;
      int b;
      int ll;
      int lpf;
      logic [`PLAT_SOF_CNT_W-1:0]  f_fld;
      logic [`PLAT_EOL_CNT_W-1:0]  l_fld;
      logic [`PLAT_BEAT_CNT_W-1:0] b_fld;
      frames = 0;
      lines  = 0;
      beats  = 0;
      for (int r = 0; r < upto; r++)
      begin
         if (row_kind[r] == K_BURST)
         begin
            b   = int'(row_data[r][15:0]);
            ll  = int'(row_data[r][23:16]);
            lpf = int'(row_data[r][31:24]);
            beats  += b;
            lines  += b / ll;
            frames += (b + ll * lpf - 1) / (ll * lpf);
         end
      end
      // Each field wraps at its own width
      f_fld = frames[`PLAT_SOF_CNT_W-1:0];
      l_fld = lines[`PLAT_EOL_CNT_W-1:0];
      b_fld = beats[`PLAT_BEAT_CNT_W-1:0];
      return {f_fld, l_fld, b_fld};
   endfunction

   //**************************************************
   // Checks and table
   //**************************************************
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_fault(input string what);
      err_cnt++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   task automatic add_row(input int kind, input logic [12:0] addr, input logic [31:0] data,
                          input logic [3:0] mask, input logic [31:0] exp);
      row_kind[n_rows] = kind;
      row_addr[n_rows] = addr;
      row_data[n_rows] = data;
      row_mask[n_rows] = mask;
      row_exp[n_rows]  = exp;
      n_rows++;
   endtask

   task automatic load_table();
      // Firmware word is read only and ignores low address bits
      add_row(K_READ,  13'h000, 32'h0, 4'h0, `PLAT_FW_VERSION);
      add_row(K_WRITE, 13'h000, 32'hDEAD_BEEF, 4'hF, 32'h0);
      add_row(K_READ,  13'h008, 32'h0, 4'h0, `PLAT_FW_VERSION);
      // Unmapped index 0x123
      add_row(K_READ,  13'h1230, 32'h0, 4'h0, 32'h0);
      add_row(K_WRITE, 13'h1230, 32'hFFFF_FFFF, 4'hF, 32'h0);
      add_row(K_READ,  13'h1230, 32'h0, 4'h0, 32'h0);
      // LED_CTRL byte lanes
      add_row(K_READ,  13'h010, 32'h0, 4'h0, 32'h0);
      add_row(K_WRITE, 13'h010, 32'h1234_5678, 4'hF, 32'h0);
      add_row(K_READ,  13'h010, 32'h0, 4'h0, 32'h1234_5678);
      add_row(K_WRITE, 13'h01C, 32'hAABB_CC0D, 4'b0101, 32'h0);
      add_row(K_READ,  13'h014, 32'h0, 4'h0, 32'h12BB_560D);
      add_row(K_WRITE, 13'h010, 32'hFFEE_DD0A, 4'b1010, 32'h0);
      add_row(K_READ,  13'h010, 32'h0, 4'h0, 32'hFFBB_DD0D);
      add_row(K_WRITE, 13'h010, 32'h0000_0003, 4'b0001, 32'h0);
      add_row(K_READ,  13'h010, 32'h0, 4'h0, 32'hFFBB_DD03);
      // Mask bit 0 of a burst allows idle gaps
      add_row(K_BURST, 13'h000, burst_cfg(2, 4, 16), 4'h0, 32'h0);
      add_row(K_BURST, 13'h000, burst_cfg(3, 5, 18), 4'h1, 32'h0);
      // Count register is read only
      add_row(K_WRITE, 13'h020, 32'hFFFF_FFFF, 4'hF, 32'h0);
      add_row(K_READ,  13'h020, 32'h0, 4'h0, count_word(n_rows));
      add_row(K_BURST, 13'h000, burst_cfg(1, 3, 7), 4'h1, 32'h0);
      add_row(K_READ,  13'h020, 32'h0, 4'h0, count_word(n_rows));
      // One frame per beat pushes the frame-start field past 255
      add_row(K_BURST, 13'h000, burst_cfg(1, 1, 250), 4'h0, 32'h0);
      add_row(K_READ,  13'h020, 32'h0, 4'h0, count_word(n_rows));
      add_row(K_READ,  13'h000, 32'h0, 4'h0, `PLAT_FW_VERSION);
   endtask

   //**************************************************
   // Bus and stream drivers
   //**************************************************
   task automatic write_reg(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
      @(posedge reg_ctrl_clk);
      reg_en_i    <= 1'b1;
      reg_we_i    <= mask;
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      @(posedge reg_ctrl_clk);
      reg_en_i <= 1'b0;
      reg_we_i <= '0;
      if (addr[12:4] == 9'd1)
         led_shadow = merge_lanes(led_shadow, data, mask);
      // LED pins follow one cycle after the write
      @(negedge reg_ctrl_clk);
      check_val("led_o", 32'(led_o), 32'(led_shadow[3:0]));
   endtask

   task automatic read_reg(input logic [12:0] addr, input logic [31:0] exp);
      @(posedge reg_ctrl_clk);
      reg_en_i   <= 1'b1;
      reg_we_i   <= '0;
      reg_addr_i <= addr;
      @(posedge reg_ctrl_clk);
      reg_en_i <= 1'b0;
      @(negedge reg_ctrl_clk);
      check_val("reg_rdata_o", reg_rdata_o, exp);
      if (addr[12:4] == 9'd2)
         check_val("mon_cnt_o", mon_cnt_o, exp);
   endtask

   task automatic run_burst(input logic [31:0] cfg, input logic gaps);
      int beats;
      int ll;
      int frame_len;
      beats     = int'(cfg[15:0]);
      ll        = int'(cfg[23:16]);
      frame_len = ll * int'(cfg[31:24]);
      for (int i = 0; i < beats; i++)
      begin
         // Idle cycle with junk on the pixel bus
         if (gaps && ($urandom % 4 == 0))
         begin
            @(posedge reg_ctrl_clk);
            cam_valid_i <= 1'b0;
            cam_sof_i   <= 1'b0;
            cam_eol_i   <= 1'b0;
            cam_pix_i   <= 16'($urandom);
         end
         @(posedge reg_ctrl_clk);
         cam_valid_i <= 1'b1;
         cam_sof_i   <= (i % frame_len == 0);
         cam_eol_i   <= (i % ll == ll - 1);
         cam_pix_i   <= 16'($urandom);
      end
      @(posedge reg_ctrl_clk);
      cam_valid_i <= 1'b0;
      cam_sof_i   <= 1'b0;
      cam_eol_i   <= 1'b0;
      // Let the counts settle
      repeat (2) @(posedge reg_ctrl_clk);
   endtask

   task automatic check_outputs_idle();
      check_val("led_o", 32'(led_o), 32'h0);
      check_val("reg_rdata_o", reg_rdata_o, 32'h0);
      check_val("mon_cnt_o", mon_cnt_o, 32'h0);
   endtask

   // Traffic sent before ready must all be dropped
   task automatic drive_early_traffic(input int n);
      case (n)
         3:
         begin
            cam_valid_i <= 1'b1;
            cam_sof_i   <= 1'b1;
            cam_eol_i   <= 1'b1;
            cam_pix_i   <= 16'hFFFF;
         end
         4:
         begin
            cam_valid_i <= 1'b0;
            reg_en_i    <= 1'b1;
            reg_we_i    <= 4'hF;
            reg_addr_i  <= 13'h010;
            reg_wdata_i <= 32'h0000_000F;
         end
         5:
         begin
            reg_en_i <= 1'b0;
            reg_we_i <= '0;
         end
         6:
         begin
            reg_en_i   <= 1'b1;
            reg_addr_i <= 13'h000;
         end
         7:
            reg_en_i <= 1'b0;
         default:
            ;
      endcase
   endtask

   //**************************************************
   // Pixel stream reference check
   //**************************************************
   always @(negedge reg_ctrl_clk)
   begin
      if (rst_n_i !== 1'b1)
      begin
         exp_valid = 1'b0;
         exp_sof   = 1'b0;
         exp_eol   = 1'b0;
      end
      else
      begin
         check_val("pix_valid_o", 32'(pix_valid_o), 32'(exp_valid));
         check_val("pix_sof_o", 32'(pix_sof_o), 32'(exp_sof));
         check_val("pix_eol_o", 32'(pix_eol_o), 32'(exp_eol));
         if (exp_valid)
            check_val("pix_data_o", 32'(pix_data_o), 32'(exp_data));
         // Inputs seen here are taken at the next rising edge
         exp_valid = cam_valid_i && sys_ready_o;
         exp_sof   = exp_valid && cam_sof_i;
         exp_eol   = exp_valid && cam_eol_i;
         exp_data  = rgb565_to_888(cam_pix_i);
      end
   end

   //**************************************************
   // Main sequence
   //**************************************************
   initial
   begin
      int edges;
      rst_n_i     = 1'b0;
      reg_en_i    = 1'b0;
      reg_we_i    = '0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      cam_valid_i = 1'b0;
      cam_sof_i   = 1'b0;
      cam_eol_i   = 1'b0;
      cam_pix_i   = '0;
      err_cnt     = 0;
      chk_cnt     = 0;
      n_rows      = 0;
      led_shadow  = '0;
      ready_ok    = 1'b0;
      void'($urandom(32'h74bd));
      load_table();
      table_loaded = 1'b1;

      // Reset released on the last held edge
      for (int i = 0; i < RST_CYCLES; i++)
      begin
         @(posedge reg_ctrl_clk);
         if (i == RST_CYCLES - 1)
            rst_n_i <= 1'b1;
         @(negedge reg_ctrl_clk);
         check_outputs_idle();
         check_val("sys_ready_o", 32'(sys_ready_o), 32'h0);
      end

      // Count edges until ready
      edges = 0;
      while (!ready_ok && edges < 4 * `PLAT_POR_CYCLES)
      begin
         @(posedge reg_ctrl_clk);
         edges++;
         drive_early_traffic(edges);
         @(negedge reg_ctrl_clk);
         if (sys_ready_o)
            ready_ok = 1'b1;
         else
            check_outputs_idle();
      end

      if (!ready_ok)
         report_fault("sys_ready_o never rose after reset release");
      else
      begin
         check_val("sys_ready_o edge count", 32'(edges), 32'(`PLAT_POR_CYCLES));
         for (int r = 0; r < n_rows; r++)
         begin
            case (row_kind[r])
               K_WRITE: write_reg(row_addr[r], row_data[r], row_mask[r]);
               K_READ:  read_reg(row_addr[r], row_exp[r]);
               K_BURST: run_burst(row_data[r], row_mask[r][0]);
               default: report_fault("unknown operation kind in table");
            endcase
         end
      end

      repeat (4) @(posedge reg_ctrl_clk);
      $display("checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog budget per table row plus power-on
   initial
   begin
      int wd_cycles;
      wait (table_loaded);
      wd_cycles = n_rows * ROW_BUDGET + RST_CYCLES + `PLAT_POR_CYCLES;
      repeat (wd_cycles) @(posedge reg_ctrl_clk);
      $display("timeout: run still busy after %0d cycles", wd_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: testbench/tb_clock_gen.sv
//**************************************************
// Testbench clock source, free-running square wave
//**************************************************
`timescale 1ns/1ps

module tb_clock_gen
#(
   parameter int PERIOD_NS = 8
)
(
   output logic clk_o
);

   // Starts low, first rising edge at half a period
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule
